// File: hw/jamPkg.sv
`default_nettype none

package jamPkg;

    localparam int NumAgents  = 8;
    localparam int IndexWidth = 3;
    localparam int CostWidth  = 7;
    localparam int SumWidth   = 10;
    localparam int CountWidth = 16;
    localparam int TableDepth = 64;

    // APB byte addresses with one word per cost entry
    localparam logic [11:0] CostBase       = 12'h000;
    localparam logic [11:0] CtrlAddr       = 12'h100;
    localparam logic [11:0] StatusAddr     = 12'h104;
    localparam logic [11:0] MinCostAddr    = 12'h108;
    localparam logic [11:0] MatchCountAddr = 12'h10C;

    typedef struct packed {
        logic [NumAgents-1:0][IndexWidth-1:0] job; // Slot w holds the job of worker w
    } assignment_t;

    typedef struct packed {
        logic                  valid;
        logic [IndexWidth-1:0] worker;
        logic [IndexWidth-1:0] job;
    } costReq_t;

    typedef struct packed {
        logic                    en;
        logic [2*IndexWidth-1:0] index; // Worker times eight plus job
        logic [CostWidth-1:0]    cost;
    } costWrite_t;

    typedef struct packed {
        logic [SumWidth-1:0]   minCost;
        logic [CountWidth-1:0] matchCount;
    } searchResult_t;

endpackage

`default_nettype wire

// File: hw/permutationStepper.sv
`timescale 1ns/1ps
`default_nettype none

module permutationStepper import jamPkg::*;
(
    input  logic        CLK,
    input  logic        RST,
    input  logic        init,
    input  logic        step,
    output assignment_t curAssign,
    output logic        stepDone,
    output logic        last
);

    typedef enum logic [1:0] {Waiting, Scanning, Swapping, Reversing} stepState_t;

    stepState_t            state;
    logic [IndexWidth-1:0] pivot;
    logic [IndexWidth-1:0] swapPos;
    logic [IndexWidth-1:0] scanPos;
    logic [IndexWidth-1:0] lo;
    logic [IndexWidth-1:0] hi;
    logic [IndexWidth-1:0] ascentPos;
    logic                  ascentFound;

    function automatic assignment_t identity();
        assignment_t a;
        for (int w = 0; w < NumAgents; w++)
        begin
            a.job[w] = IndexWidth'(w);
        end
        return a;
    endfunction

    function automatic logic isPermutation(assignment_t a);
        logic [NumAgents-1:0] seen;
        seen = '0;
        for (int w = 0; w < NumAgents; w++)
        begin
            seen[a.job[w]] = 1'b1;
        end
        return &seen;
    endfunction

    // Rightmost position whose job is smaller than its right neighbour's
    always_comb
    begin
        ascentPos   = '0;
        ascentFound = 1'b0;
        for (int i = 0; i < NumAgents - 1; i++)
        begin
            if (curAssign.job[i] < curAssign.job[i + 1])
            begin
                ascentPos   = IndexWidth'(i);
                ascentFound = 1'b1;
            end
        end
    end

    assign last = !ascentFound; // Fully descending

    always_ff @(posedge CLK or posedge RST)
    begin
        if (RST)
        begin
            state     <= Waiting;
            curAssign <= identity();
            pivot     <= '0;
            swapPos   <= '0;
            scanPos   <= '0;
            lo        <= '0;
            hi        <= '0;
            stepDone  <= 1'b0;
        end
        else if (init)
        begin
            state     <= Waiting;
            curAssign <= identity();
            stepDone  <= 1'b0;
        end
        else
        begin
            stepDone <= 1'b0;
            case (state)
                Waiting:
                begin
                    if (step && ascentFound)
                    begin
                        pivot   <= ascentPos;
                        swapPos <= ascentPos + IndexWidth'(1); // Largest job of the suffix
                        scanPos <= IndexWidth'(NumAgents - 1);
                        if (ascentPos == IndexWidth'(NumAgents - 2))
                            state <= Swapping;
                        else
                            state <= Scanning;
                    end
                    else if (step)
                        stepDone <= 1'b1; // Nothing follows the last one
                end
                Scanning:
                begin
                    if (curAssign.job[scanPos] > curAssign.job[pivot] &&
                        curAssign.job[scanPos] < curAssign.job[swapPos])
                        swapPos <= scanPos;
                    if (scanPos == pivot + IndexWidth'(2))
                        state <= Swapping;
                    else
                        scanPos <= scanPos - IndexWidth'(1);
                end
                Swapping:
                begin
                    curAssign.job[pivot]   <= curAssign.job[swapPos];
                    curAssign.job[swapPos] <= curAssign.job[pivot];
                    lo    <= pivot + IndexWidth'(1);
                    hi    <= IndexWidth'(NumAgents - 1);
                    state <= Reversing;
                end
                Reversing:
                begin
                    if (lo < hi)
                    begin
                        curAssign.job[lo] <= curAssign.job[hi]; // One pair per cycle
                        curAssign.job[hi] <= curAssign.job[lo];
                        lo <= lo + IndexWidth'(1);
                        hi <= hi - IndexWidth'(1);
                    end
                    else
                    begin
                        stepDone <= 1'b1;
                        state    <= Waiting;
                    end
                end
                default: state <= Waiting;
            endcase
        end
    end

    assert property (@(posedge CLK) disable iff (RST) isPermutation(curAssign))
        else $error("assignment no longer holds each job once");

endmodule

`default_nettype wire

// File: hw/costAccumulator.sv
`timescale 1ns/1ps
`default_nettype none

module costAccumulator import jamPkg::*;
(
    input  logic                 CLK,
    input  logic                 RST,
    input  logic                 clear,
    input  logic                 costValid,
    input  logic [CostWidth-1:0] cost,
    output searchResult_t        result
);

    logic [IndexWidth-1:0] costCount;
    logic [SumWidth-1:0]   partialSum;
    logic [SumWidth-1:0]   total;
    logic                  totalValid;
    logic                  lastCost;

    assign lastCost = costValid && (costCount == IndexWidth'(NumAgents - 1));

    always_ff @(posedge CLK or posedge RST)
    begin
        if (RST)
        begin
            costCount  <= '0;
            partialSum <= '0;
            totalValid <= 1'b0;
        end
        else if (clear)
        begin
            costCount  <= '0;
            partialSum <= '0;
            totalValid <= 1'b0;
        end
        else
        begin
            totalValid <= lastCost;
            if (costValid)
            begin
                costCount <= costCount + IndexWidth'(1); // Wraps after eight
                if (lastCost)
                    partialSum <= '0;
                else
                    partialSum <= partialSum + SumWidth'(cost);
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (lastCost)
            total <= partialSum + SumWidth'(cost);
    end

    // Fold one cycle after the eighth cost
    always_ff @(posedge CLK or posedge RST)
    begin
        if (RST)
        begin
            result.minCost    <= '1;
            result.matchCount <= '0;
        end
        else if (clear)
        begin
            result.minCost    <= '1;
            result.matchCount <= '0;
        end
        else if (totalValid)
        begin
            if (total < result.minCost)
            begin
                result.minCost    <= total;
                result.matchCount <= CountWidth'(1);
            end
            else if (total == result.minCost)
                result.matchCount <= result.matchCount + CountWidth'(1);
        end
    end

endmodule

`default_nettype wire

// File: hw/jamSearch.sv
`timescale 1ns/1ps
`default_nettype none

module jamSearch import jamPkg::*;
(
    input  logic                 CLK,
    input  logic                 RST,
    input  logic                 start,
    output logic                 busy,
    output logic                 done,
    output searchResult_t        result,
    output costReq_t             costReq,
    input  logic [CostWidth-1:0] cost
);

    typedef enum logic [1:0] {Idle, Lookup, Stepping, Draining} searchState_t;

    searchState_t          state;
    logic [IndexWidth-1:0] worker;
    logic                  launch;
    logic                  stepGo;
    logic                  stepDone;
    logic                  last;
    logic                  costValid;
    assignment_t           curAssign;

    assign busy   = (state != Idle);
    assign launch = (state == Idle) && start;
    assign stepGo = (state == Lookup) && (worker == IndexWidth'(NumAgents - 1)) && !last;

    assign costReq.valid  = (state == Lookup);
    assign costReq.worker = worker;
    assign costReq.job    = curAssign.job[worker];

    always_ff @(posedge CLK or posedge RST)
    begin
        if (RST)
        begin
            state     <= Idle;
            worker    <= '0;
            done      <= 1'b0;
            costValid <= 1'b0;
        end
        else
        begin
            done      <= 1'b0;
            costValid <= costReq.valid; // Cost comes back one cycle later
            case (state)
                Idle:
                begin
                    if (start)
                    begin
                        worker <= '0;
                        state  <= Lookup;
                    end
                end
                Lookup:
                begin
                    worker <= worker + IndexWidth'(1); // Back to zero after worker 7
                    if (worker == IndexWidth'(NumAgents - 1))
                        state <= last ? Draining : Stepping;
                end
                Stepping:
                begin
                    if (stepDone)
                        state <= Lookup;
                end
                Draining:
                begin
                    // Last cost lands, then the accumulator folds it
                    worker <= worker + IndexWidth'(1);
                    if (worker == IndexWidth'(1))
                    begin
                        done  <= 1'b1;
                        state <= Idle;
                    end
                end
                default: state <= Idle;
            endcase
        end
    end

    permutationStepper stepper (
        .CLK       (CLK),
        .RST       (RST),
        .init      (launch),
        .step      (stepGo),
        .curAssign (curAssign),
        .stepDone  (stepDone),
        .last      (last)
    );

    costAccumulator accumulator (
        .CLK       (CLK),
        .RST       (RST),
        .clear     (launch),
        .costValid (costValid),
        .cost      (cost),
        .result    (result)
    );

    assert property (@(posedge CLK) disable iff (RST) start |-> !busy)
        else $error("start issued while a search is running");

endmodule

`default_nettype wire

// File: hw/costTable.sv
`timescale 1ns/1ps
`default_nettype none

module costTable import jamPkg::*;
(
    input  logic                 CLK,
    input  logic                 RST,
    input  costWrite_t           write,
    input  costReq_t             costReq,
    output logic [CostWidth-1:0] cost
);

    logic [CostWidth-1:0]    entries [TableDepth];
    logic [2*IndexWidth-1:0] readIndex;

    assign readIndex = {costReq.worker, costReq.job}; // Worker times eight plus job

    always_ff @(posedge CLK or posedge RST)
    begin
        if (RST)
        begin
            for (int i = 0; i < TableDepth; i++)
            begin
                entries[i] <= '0;
            end
        end
        else if (write.en)
            entries[write.index] <= write.cost;
    end

    // Registered lookup that takes one request per cycle
    always_ff @(posedge CLK)
    begin
        if (costReq.valid)
            cost <= entries[readIndex];
    end

endmodule

`default_nettype wire

// File: hw/jamApbRegs.sv
`timescale 1ns/1ps
`default_nettype none

module jamApbRegs import jamPkg::*;
(
    input  logic          CLK,
    input  logic          RST,
    input  logic          PSEL,
    input  logic          PENABLE,
    input  logic          PWRITE,
    input  logic [11:0]   PADDR,
    input  logic [31:0]   PWDATA,
    output logic [31:0]   PRDATA,
    output logic          PREADY,
    output logic          PSLVERR,
    output costWrite_t    write,
    output logic          start,
    input  logic          busy,
    input  logic          done,
    input  searchResult_t result
);

    logic          access;
    logic          inCostArea;
    logic          mapped;
    logic          doneFlag;
    searchResult_t lastResult;

    assign access     = PSEL && PENABLE;
    assign inCostArea = (PADDR[11:8] == CostBase[11:8]) && (PADDR[1:0] == 2'b00); // Word-aligned
    assign mapped     = inCostArea || (PADDR == CtrlAddr) || (PADDR == StatusAddr) ||
                        (PADDR == MinCostAddr) || (PADDR == MatchCountAddr);

    assign PREADY  = 1'b1; // No wait states
    assign PSLVERR = access && (!mapped || (inCostArea && (!PWRITE || busy)));

    assign write.en    = access && PWRITE && inCostArea && !busy;
    assign write.index = PADDR[7:2];
    assign write.cost  = PWDATA[CostWidth-1:0];

    assign start = access && PWRITE && (PADDR == CtrlAddr) && PWDATA[0] && !busy;

    always_ff @(posedge CLK or posedge RST)
    begin
        if (RST)
        begin
            doneFlag              <= 1'b0;
            lastResult.minCost    <= '1;
            lastResult.matchCount <= '0;
        end
        else
        begin
            if (start)
                doneFlag <= 1'b0; // Sticky until the next search
            else if (done)
                doneFlag <= 1'b1;
            if (done)
                lastResult <= result;
        end
    end

    always_comb
    begin
        PRDATA = '0;
        case (PADDR)
            StatusAddr:     PRDATA[1:0] = {doneFlag, busy};
            MinCostAddr:    PRDATA[SumWidth-1:0] = lastResult.minCost;
            MatchCountAddr: PRDATA[CountWidth-1:0] = lastResult.matchCount;
            default:        PRDATA = '0;
        endcase
    end

    assert property (@(posedge CLK) disable iff (RST) PENABLE |-> PSEL)
        else $error("PENABLE high without PSEL");

endmodule

`default_nettype wire

// File: hw/jamTop.sv
`timescale 1ns/1ps
`default_nettype none

module jamTop import jamPkg::*;
(
    input  logic        CLK,
    input  logic        RST,
    input  logic        PSEL,
    input  logic        PENABLE,
    input  logic        PWRITE,
    input  logic [11:0] PADDR,
    input  logic [31:0] PWDATA,
    output logic [31:0] PRDATA,
    output logic        PREADY,
    output logic        PSLVERR
);

    costWrite_t           tableWrite;
    costReq_t             costReq;
    logic [CostWidth-1:0] cost;
    logic                 start;
    logic                 busy;
    logic                 done;
    searchResult_t        result;

    jamApbRegs regs (
        .CLK     (CLK),
        .RST     (RST),
        .PSEL    (PSEL),
        .PENABLE (PENABLE),
        .PWRITE  (PWRITE),
        .PADDR   (PADDR),
        .PWDATA  (PWDATA),
        .PRDATA  (PRDATA),
        .PREADY  (PREADY),
        .PSLVERR (PSLVERR),
        .write   (tableWrite),
        .start   (start),
        .busy    (busy),
        .done    (done),
        .result  (result)
    );

    costTable table0 (
        .CLK     (CLK),
        .RST     (RST),
        .write   (tableWrite),
        .costReq (costReq),
        .cost    (cost)
    );

    jamSearch search (
        .CLK     (CLK),
        .RST     (RST),
        .start   (start),
        .busy    (busy),
        .done    (done),
        .result  (result),
        .costReq (costReq),
        .cost    (cost)
    );

endmodule

`default_nettype wire

// File: bench/jamModel.svh
`ifndef JAM_MODEL_SVH
`define JAM_MODEL_SVH

int modelTable [TableDepth]; // Copy of the table as the host wrote it
int modelMin;
int modelCount;

// Brute force over every assignment in lexicographic order
function automatic void runModel();
    int perm [NumAgents];
    int sum;
    int pivot;
    int swapAt;
    int tmp;
    int lo;
    int hi;
    bit more;
    for (int w = 0; w < NumAgents; w++)
    begin
        perm[w] = w;
    end
    modelMin   = 1 << SumWidth;
    modelCount = 0;
    more       = 1'b1;
    while (more)
    begin
        sum = 0;
        for (int w = 0; w < NumAgents; w++)
        begin
            sum += modelTable[w * NumAgents + perm[w]];
        end
        if (sum < modelMin)
        begin
            modelMin   = sum;
            modelCount = 1;
        end
        else if (sum == modelMin)
            modelCount++;
        pivot = NumAgents - 2;
        while (pivot >= 0)
        begin
            if (perm[pivot] < perm[pivot + 1])
                break;
            pivot--;
        end
        if (pivot < 0)
            more = 1'b0; // Descending order reached
        else
        begin
            swapAt = NumAgents - 1;
            while (perm[swapAt] < perm[pivot])
            begin
                swapAt--;
            end
            tmp          = perm[pivot];
            perm[pivot]  = perm[swapAt];
            perm[swapAt] = tmp;
            lo = pivot + 1;
            hi = NumAgents - 1;
            while (lo < hi)
            begin
                tmp      = perm[lo];
                perm[lo] = perm[hi];
                perm[hi] = tmp;
                lo++;
                hi--;
            end
        end
    end
endfunction

`endif

// File: bench/jamTb.sv
`timescale 1ns/1ps
`default_nettype none

module jamTb import jamPkg::*;
();

    localparam int ClockPeriod  = 20;
    localparam int Permutations = 40320;
    localparam int SearchesRun  = 4;
    localparam int WorstCycles  = 20; // Per assignment when the pivot is worker 0
    localparam int MaxPolls     = Permutations * WorstCycles / 3 + 1000;
    localparam int WatchdogNs   = SearchesRun * Permutations * WorstCycles * ClockPeriod + 1000000;

    logic        CLK;
    logic        RST;
    logic        PSEL;
    logic        PENABLE;
    logic        PWRITE;
    logic [11:0] PADDR;
    logic [31:0] PWDATA;
    logic [31:0] PRDATA;
    logic        PREADY;
    logic        PSLVERR;

    int errorCount;
    int testErrors;
    int testsClean;
    int testsDirty;

    `include "jamModel.svh"

    jamTop dut0 (
        .CLK     (CLK),
        .RST     (RST),
        .PSEL    (PSEL),
        .PENABLE (PENABLE),
        .PWRITE  (PWRITE),
        .PADDR   (PADDR),
        .PWDATA  (PWDATA),
        .PRDATA  (PRDATA),
        .PREADY  (PREADY),
        .PSLVERR (PSLVERR)
    );

    initial
    begin
        CLK = 1'b0;
        forever #(ClockPeriod / 2) CLK = ~CLK;
    end

    initial
    begin
        #(WatchdogNs);
        $display("timeout: the searches did not finish within %0d ns", WatchdogNs);
        $display("test failed");
        $finish;
    end

    task automatic apbTransfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                               output logic [31:0] rdata, output logic err);
        @(posedge CLK);
        #2;
        PSEL    = 1'b1; // Setup phase
        PENABLE = 1'b0;
        PWRITE  = wr;
        PADDR   = addr;
        PWDATA  = wdata;
        @(posedge CLK);
        #2;
        PENABLE = 1'b1;
        @(negedge CLK);
        rdata = PRDATA; // Mid access phase
        err   = PSLVERR;
        checkValue("PREADY in the access phase", 1, PREADY);
        @(posedge CLK);
        #2;
        PSEL    = 1'b0;
        PENABLE = 1'b0;
        PWRITE  = 1'b0;
    endtask

    task automatic apbWrite(input logic [11:0] addr, input logic [31:0] data, output logic err);
        logic [31:0] unused;
        apbTransfer(1'b1, addr, data, unused, err);
    endtask

    task automatic apbRead(input logic [11:0] addr, output logic [31:0] data, output logic err);
        apbTransfer(1'b0, addr, '0, data, err);
    endtask

    task automatic checkValue(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("MISMATCH at %0t ns: %s expected %0d, got %0d", $time, what, expected, actual);
            errorCount++;
        end
    endtask

    task automatic finishTest(input string name);
        if (errorCount == testErrors)
        begin
            testsClean++;
            $display("[ok]     %s", name);
        end
        else
        begin
            testsDirty++;
            $display("[errors] %s: %0d", name, errorCount - testErrors);
        end
        testErrors = errorCount;
    endtask

    // Costs drawn from base up to base + span - 1
    task automatic loadTable(input int base, input int span);
        logic err;
        int   c;
        for (int i = 0; i < TableDepth; i++)
        begin
            c = base + int'($urandom % span);
            modelTable[i] = c;
            apbWrite(CostBase + 12'(i * 4), 32'(c), err);
            checkValue("cost write error flag", 0, err);
        end
    endtask

    task automatic waitForDone(input string name);
        logic [31:0] status;
        logic        err;
        int          polls;
        polls  = 0;
        status = '0;
        while (!status[1] && polls < MaxPolls)
        begin
            apbRead(StatusAddr, status, err);
            polls++;
        end
        if (!status[1])
        begin
            $display("%s: the search never reported done after %0d status polls", name, polls);
            errorCount++;
        end
        else
            checkValue({name, ": busy after done"}, 0, status[0]);
    endtask

    task automatic startSearch(input string name);
        logic err;
        apbWrite(CtrlAddr, 32'd1, err);
        checkValue({name, ": start error flag"}, 0, err);
        waitForDone(name);
    endtask

    task automatic checkResult(input string name, input int expMin, input int expCount);
        logic [31:0] data;
        logic        err;
        apbRead(MinCostAddr, data, err);
        checkValue({name, ": minimum cost"}, expMin, data);
        checkValue({name, ": minimum cost error flag"}, 0, err);
        apbRead(MatchCountAddr, data, err);
        checkValue({name, ": match count"}, expCount, data);
        checkValue({name, ": match count error flag"}, 0, err);
    endtask

    initial
    begin
        logic [31:0] data;
        logic        err;
        int          c;
        int          index;
        PSEL       = 1'b0;
        PENABLE    = 1'b0;
        PWRITE     = 1'b0;
        PADDR      = '0;
        PWDATA     = '0;
        RST        = 1'b1;
        errorCount = 0;
        testErrors = 0;
        testsClean = 0;
        testsDirty = 0;
        void'($urandom(34945));
        repeat (4) @(posedge CLK);
        #2;
        RST = 1'b0;

        apbRead(StatusAddr, data, err);
        checkValue("reset: status", 0, data);
        checkValue("reset: status error flag", 0, err);
        checkResult("reset", 1023, 0);
        finishTest("reset state");

        loadTable(0, 128);
        runModel();
        startSearch("random search");
        checkResult("random search", modelMin, modelCount);
        finishTest("random search");

        // Higher costs, so an old minimum left in place would show
        apbRead(StatusAddr, data, err);
        checkValue("restart: status before", 2, data);
        loadTable(64, 64);
        runModel();
        apbWrite(CtrlAddr, 32'd1, err);
        apbRead(StatusAddr, data, err);
        checkValue("restart: status while busy", 1, data);
        waitForDone("restart");
        checkResult("restart", modelMin, modelCount);
        finishTest("restart");

        c = int'($urandom % 128);
        loadTable(c, 1);
        startSearch("uniform table");
        checkResult("uniform table", 8 * c, Permutations);
        finishTest("uniform table");

        // A zero entry would pull the minimum below 8 * 120
        loadTable(120, 8);
        runModel();
        apbWrite(CtrlAddr, 32'd1, err);
        index = int'($urandom % TableDepth);
        apbWrite(CostBase + 12'(index * 4), 32'd0, err);
        checkValue("busy: cost write error flag", 1, err);
        apbWrite(CtrlAddr, 32'd1, err);
        checkValue("busy: second start error flag", 0, err);
        apbRead(StatusAddr, data, err);
        checkValue("busy: status", 1, data);
        waitForDone("write while busy");
        checkResult("write while busy", modelMin, modelCount);
        finishTest("write while busy");

        apbRead(CostBase, data, err);
        checkValue("bad: read of cost entry 0", 1, err);
        apbRead(CostBase + 12'h0FC, data, err);
        checkValue("bad: read of cost entry 63", 1, err);
        apbRead(CostBase + 12'(index * 4), data, err);
        checkValue("bad: read of a random cost entry", 1, err);
        apbRead(12'h110, data, err);
        checkValue("bad: read of 0x110", 1, err);
        apbRead(12'hFFC, data, err);
        checkValue("bad: read of 0xFFC", 1, err);
        apbWrite(12'h200, 32'd1, err);
        checkValue("bad: write to 0x200", 1, err);
        apbWrite(12'h101, 32'd1, err);
        checkValue("bad: write to 0x101", 1, err);
        apbWrite(12'h0FE, 32'd1, err);
        checkValue("bad: write to 0x0FE", 1, err);
        apbRead(StatusAddr, data, err);
        checkValue("bad: status afterwards", 2, data);
        checkValue("bad: status error flag", 0, err);
        finishTest("bad accesses");

        $display("summary: %0d tests clean, %0d tests with errors, %0d errors in total",
                 testsClean, testsDirty, errorCount);
        if (errorCount == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: jam.f
+incdir+bench
hw/jamPkg.sv
hw/permutationStepper.sv
hw/costAccumulator.sv
hw/jamSearch.sv
hw/costTable.sv
hw/jamApbRegs.sv
hw/jamTop.sv
bench/jamTb.sv

// File: Bender.yml
package:
  name: jam

sources:
  - hw/jamPkg.sv
  - hw/permutationStepper.sv
  - hw/costAccumulator.sv
  - hw/jamSearch.sv
  - hw/costTable.sv
  - hw/jamApbRegs.sv
  - hw/jamTop.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/jamTb.sv
